//--- rtl/periph_pkg.sv
package periph_pkg;

	// Bus word and byte lanes
	localparam int WORD_W = 32;
	localparam int BE_W   = 4;
	localparam int BYTE_W = WORD_W / BE_W;

	// Bank map, each bank spans 4 KiB
	localparam int NUM_BANKS = 3;
	localparam int BANK_W    = 2;
	localparam int BANK_LSB  = 12;

	// Register offset field inside a bank, word aligned
	localparam int OFFS_LSB = 2;
	localparam int OFFS_W   = 2;

	// Register word offsets
	localparam logic [OFFS_W-1:0] REG_OUT    = 2'd0;
	localparam logic [OFFS_W-1:0] REG_IN     = 2'd1;
	localparam logic [OFFS_W-1:0] REG_TOGGLE = 2'd2;

	// One GPIO word, written per byte lane and read as a whole
	typedef union packed {
		logic [WORD_W-1:0]            word;
		logic [BE_W-1:0][BYTE_W-1:0] bytes;
	} gpio_word_u;

	// True when the bank field selects an existing bank
	function automatic logic bank_is_mapped(input logic [BANK_W-1:0] sel);
		return int'(sel) < NUM_BANKS;
	endfunction

endpackage

//--- rtl/bus_decoder.sv
module bus_decoder import periph_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n_i,

	// Request from the master
	input  logic                 valid_i,
	input  logic [WORD_W-1:0]    addr_i,

	// Strobe per bank and the decoded selection
	output logic [NUM_BANKS-1:0] bank_valid_o,
	output logic [BANK_W-1:0]    bank_sel_o,

	// Acknowledge for unmapped addresses
	output logic                 miss_ready_o
);

	logic [BANK_W-1:0] bank_field;
	logic              mapped;
	logic              miss_valid;
	logic              miss_ready_q;

	// Bank field of the address
	assign bank_field = addr_i[BANK_LSB +: BANK_W];
	assign mapped     = bank_is_mapped(bank_field);

	// The mux reuses this, no second decode there
	assign bank_sel_o = bank_field;

	// One-hot strobe, only the addressed bank sees valid
	always_comb begin
		bank_valid_o = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (bank_field == BANK_W'(i)) begin
				bank_valid_o[i] = valid_i;
			end
		end
	end

	// Unmapped request, nobody else will answer it
	assign miss_valid = valid_i && !mapped;

	// Registered miss acknowledge
	// Same rule as a bank: one cycle late, never twice in a row
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			miss_ready_q <= 1'b0;
		end else begin
			miss_ready_q <= miss_valid && !miss_ready_q;
		end
	end

	assign miss_ready_o = miss_ready_q;

endmodule

//--- rtl/gpio_bank.sv
module gpio_bank import periph_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,

	// Bus slave port
	input  logic              valid_i,
	output logic              ready_o,

	input  logic [WORD_W-1:0] addr_i,
	input  logic [WORD_W-1:0] wdata_i,
	input  logic [BE_W-1:0]   we_i,
	output gpio_word_u        rdata_o,

	// Pins
	input  logic [WORD_W-1:0] gpio_i,
	output logic [WORD_W-1:0] gpio_o
);

	logic              ready_q;
	logic              access;
	logic              is_write;
	logic [OFFS_W-1:0] offset;

	gpio_word_u        wdata_u;
	gpio_word_u        out_q;
	gpio_word_u        out_d;
	gpio_word_u        rd_word;
	gpio_word_u        rdata_q;

	// Two-flop input synchronizer
	logic [WORD_W-1:0] sync_q;
	logic [WORD_W-1:0] in_q;

	assign offset   = addr_i[OFFS_LSB +: OFFS_W];
	assign is_write = |we_i;
	assign wdata_u  = wdata_i;

	// Accept only when not acknowledging, gives the 2 cycle repeat
	assign access = valid_i && !ready_q;

	// Next value of the output register, byte lane by byte lane
	always_comb begin
		out_d = out_q;
		if (access && is_write) begin
			for (int b = 0; b < BE_W; b++) begin
				if (we_i[b]) begin
					case (offset)
						REG_OUT: begin
							out_d.bytes[b] = wdata_u.bytes[b];
						end
						REG_TOGGLE: begin
							out_d.bytes[b] = out_q.bytes[b] ^ wdata_u.bytes[b];
						end
						default: begin
							out_d.bytes[b] = out_q.bytes[b];
						end
					endcase
				end
			end
		end
	end

	// Read word, zero for writes and for toggle or unused offsets
	always_comb begin
		rd_word = '0;
		if (!is_write) begin
			case (offset)
				REG_OUT: rd_word = out_q;
				REG_IN:  rd_word.word = in_q;
				default: rd_word = '0;
			endcase
		end
	end

	// Control, pin and sample state
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ready_q <= 1'b0;
			out_q   <= '0;
			sync_q  <= '0;
			in_q    <= '0;
		end else begin
			ready_q <= access;
			out_q   <= out_d;
			sync_q  <= gpio_i;
			in_q    <= sync_q;
		end
	end

	// Response data, captured with the request
	always_ff @(posedge clk) begin
		if (access) begin
			rdata_q <= rd_word;
		end
	end

	assign ready_o = ready_q;
	assign rdata_o = rdata_q;
	assign gpio_o  = out_q.word;

endmodule

//--- rtl/bus_resp_mux.sv
module bus_resp_mux import periph_pkg::*; (
	// Selection from the decoder
	input  logic [BANK_W-1:0]                bank_sel_i,

	// Bank responses
	input  logic [NUM_BANKS-1:0]             bank_ready_i,
	input  gpio_word_u [NUM_BANKS-1:0]       bank_rdata_i,

	// Unmapped acknowledge, data is always zero
	input  logic                             miss_ready_i,

	// Return to the master
	output logic                             ready_o,
	output logic [WORD_W-1:0]                rdata_o
);

	logic              sel_ready;
	logic [WORD_W-1:0] sel_rdata;

	always_comb begin
		sel_ready = 1'b0;
		sel_rdata = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (bank_sel_i == BANK_W'(i)) begin
				sel_ready = bank_ready_i[i];
				sel_rdata = bank_rdata_i[i].word;
			end
		end
		// No bank behind this field
		if (!bank_is_mapped(bank_sel_i)) begin
			sel_ready = miss_ready_i;
			sel_rdata = '0;
		end
	end

	assign ready_o = sel_ready;

	// Data only shows with ready
	assign rdata_o = sel_ready ? sel_rdata : '0;

endmodule

//--- rtl/periph_top.sv
module periph_top import periph_pkg::*; (
	input  logic                             clk,
	input  logic                             rst_n_i,

	// Data memory port of the core
	input  logic                             valid_i,
	output logic                             ready_o,

	input  logic [WORD_W-1:0]                addr_i,
	input  logic [WORD_W-1:0]                wdata_i,
	input  logic [BE_W-1:0]                  we_i,
	output logic [WORD_W-1:0]                rdata_o,

	// GPIO pins, one word per bank
	input  logic [NUM_BANKS-1:0][WORD_W-1:0] gpio_i,
	output logic [NUM_BANKS-1:0][WORD_W-1:0] gpio_o
);

	logic [NUM_BANKS-1:0]       bank_valid;
	logic [BANK_W-1:0]          bank_sel;
	logic                       miss_ready;

	logic [NUM_BANKS-1:0]       bank_ready;
	gpio_word_u [NUM_BANKS-1:0] bank_rdata;

	bus_decoder decoder_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),

		.valid_i     (valid_i),
		.addr_i      (addr_i),

		.bank_valid_o(bank_valid),
		.bank_sel_o  (bank_sel),
		.miss_ready_o(miss_ready)
	);

	// Address, data and byte enables fan out to every bank
	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		gpio_bank bank_i (
			.clk    (clk),
			.rst_n_i(rst_n_i),

			.valid_i(bank_valid[i]),
			.ready_o(bank_ready[i]),

			.addr_i (addr_i),
			.wdata_i(wdata_i),
			.we_i   (we_i),
			.rdata_o(bank_rdata[i]),

			.gpio_i (gpio_i[i]),
			.gpio_o (gpio_o[i])
		);
	end

	bus_resp_mux resp_mux_i (
		.bank_sel_i  (bank_sel),
		.bank_ready_i(bank_ready),
		.bank_rdata_i(bank_rdata),
		.miss_ready_i(miss_ready),

		.ready_o     (ready_o),
		.rdata_o     (rdata_o)
	);

endmodule

//--- verification/periph_assertions.sv
module periph_assertions import periph_pkg::*; (
	input logic                 clk,
	input logic                 rst_n_i,
	input logic                 valid_i,
	input logic                 ready_i,
	input logic [NUM_BANKS-1:0] bank_valid_i
);

	int fail_count = 0;

	// Every acknowledge answers a request seen one cycle earlier
	a_ready_after_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
		ready_i |-> $past(valid_i))
	else begin
		$error("ready without valid in the previous cycle");
		fail_count++;
	end

	// Single cycle pulse
	a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		ready_i |=> !ready_i)
	else begin
		$error("ready high for two consecutive cycles");
		fail_count++;
	end

	a_bank_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(bank_valid_i))
	else begin
		$error("more than one bank valid");
		fail_count++;
	end

endmodule

bind periph_top periph_assertions assertions_i (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.valid_i     (valid_i),
	.ready_i     (ready_o),
	.bank_valid_i(bank_valid)
);

//--- verification/periph_tb.sv
module periph_tb import periph_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 4;
	localparam int CYCLES_PER_TX = 12;

	logic                             clk;
	logic                             rst_n_i;
	logic                             valid_i;
	logic                             ready_o;
	logic [WORD_W-1:0]                addr_i;
	logic [WORD_W-1:0]                wdata_i;
	logic [BE_W-1:0]                  we_i;
	logic [WORD_W-1:0]                rdata_o;
	logic [NUM_BANKS-1:0][WORD_W-1:0] gpio_i;
	logic [NUM_BANKS-1:0][WORD_W-1:0] gpio_o;

	// Transactions loaded from the trace
	byte               op_q[$];
	logic [WORD_W-1:0] addr_q[$];
	logic [WORD_W-1:0] wdata_q[$];
	logic [BE_W-1:0]   be_q[$];
	logic [WORD_W-1:0] pins_q[$];
	gpio_word_u        exp_rdata_q[$];
	gpio_word_u        exp_gpio_q[$];

	// Expected gpio_o per bank from the trace
	gpio_word_u        last_gpio [NUM_BANKS];

	logic [31:0]       lcg_state;
	int                cycle_count;
	int                timeout_limit;

	periph_top dut_i (
		.clk    (clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.ready_o(ready_o),
		.addr_i (addr_i),
		.wdata_i(wdata_i),
		.we_i   (we_i),
		.rdata_o(rdata_o),
		.gpio_i (gpio_i),
		.gpio_o (gpio_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic fail_run();
		$display("tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_rdata(input gpio_word_u got, input gpio_word_u exp, input int idx);
		if (got.word !== exp.word) begin
			$display("FAIL %0t: tx %0d rdata %08h, expected %08h", $time, idx, got.word, exp.word);
			fail_run();
		end
	endtask

	task automatic check_pins(input gpio_word_u got, input gpio_word_u exp, input int bank,
			input int idx);
		if (got.word !== exp.word) begin
			$display("FAIL %0t: tx %0d gpio_o[%0d] %08h, expected %08h", $time, idx, bank,
				got.word, exp.word);
			fail_run();
		end
	endtask

	task automatic check_latency(input int got, input int idx);
		if (got != 1) begin
			$display("FAIL %0t: tx %0d ready after %0d cycles, expected 1", $time, idx, got);
			fail_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Idle gap of 0 to 3 cycles
	function automatic int next_gap();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[17:16]);
	endfunction

	// Watchdog and bound assertion errors
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (dut_i.assertions_i.fail_count != 0) begin
			$display("A bus timing assertion failed before cycle %0d", cycle_count);
			fail_run();
		end else if (timeout_limit > 0 && cycle_count > timeout_limit) begin
			$display("Timeout: the run hung, still busy after %0d cycles", cycle_count);
			fail_run();
		end
	end

	initial begin : stimulus
		int                fd;
		int                fields;
		int                bank;
		int                latency;
		string             line;
		byte               op;
		logic [WORD_W-1:0] f_addr;
		logic [WORD_W-1:0] f_wdata;
		logic [BE_W-1:0]   f_be;
		logic [WORD_W-1:0] f_pins;
		logic [WORD_W-1:0] f_rdata;
		logic [WORD_W-1:0] f_gpio;
		gpio_word_u        got_u;

		rst_n_i       = 1'b0;
		valid_i       = 1'b0;
		addr_i        = '0;
		wdata_i       = '0;
		we_i          = '0;
		gpio_i        = '0;
		lcg_state     = 32'd82;
		cycle_count   = 0;
		timeout_limit = 0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			last_gpio[b] = '0;
		end

		fd = $fopen("verification/periph_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file verification/periph_trace.txt");
			fail_run();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%c %h %h %h %h %h %h", op, f_addr, f_wdata, f_be,
					f_pins, f_rdata, f_gpio);
				if (fields != 7) begin
					$display("Malformed trace line: %s", line);
					fail_run();
				end
				op_q.push_back(op);
				addr_q.push_back(f_addr);
				wdata_q.push_back(f_wdata);
				be_q.push_back(f_be);
				pins_q.push_back(f_pins);
				exp_rdata_q.push_back(f_rdata);
				exp_gpio_q.push_back(f_gpio);
			end
		end
		$fclose(fd);
		timeout_limit = op_q.size() * CYCLES_PER_TX + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n_i = 1'b1;

		for (int idx = 0; idx < op_q.size(); idx++) begin
			bank = int'(addr_q[idx][BANK_LSB +: BANK_W]);
			// Pins and expected outputs only exist for real banks
			if (bank < NUM_BANKS) begin
				gpio_i[bank] = pins_q[idx];
				last_gpio[bank] = exp_gpio_q[idx];
			end
			repeat (3) next_cycle();
			repeat (next_gap()) next_cycle();

			valid_i = 1'b1;
			addr_i  = addr_q[idx];
			wdata_i = wdata_q[idx];
			we_i    = (op_q[idx] == "W") ? be_q[idx] : '0;
			latency = 0;
			do begin
				next_cycle();
				latency++;
			end while (!ready_o);

			check_latency(latency, idx);
			got_u = rdata_o;
			check_rdata(got_u, exp_rdata_q[idx], idx);
			for (int b = 0; b < NUM_BANKS; b++) begin
				got_u = gpio_o[b];
				check_pins(got_u, last_gpio[b], b, idx);
			end
			valid_i = 1'b0;
			we_i    = '0;
		end

		next_cycle();
		if (dut_i.assertions_i.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("Bus timing assertions failed %0d times", dut_i.assertions_i.fail_count);
			fail_run();
		end
	end

endmodule

//--- verification/periph_trace.txt
# op addr wdata be pins exp_rdata exp_gpio (hex, be ignored for R)
# pins go to the addressed bank, exp_gpio is ignored for unmapped banks
R 00000000 00000000 0 00000000 00000000 00000000
R 00001000 00000000 0 00000000 00000000 00000000
R 00002000 00000000 0 00000000 00000000 00000000
W 00000000 A5A5A5A5 F 00000000 00000000 A5A5A5A5
W 00001000 12345678 F 00000000 00000000 12345678
W 00002000 CAFEF00D F 00000000 00000000 CAFEF00D
R 00000000 00000000 0 00000000 A5A5A5A5 A5A5A5A5
R 00001000 00000000 0 00000000 12345678 12345678
R 00002000 00000000 0 00000000 CAFEF00D CAFEF00D
W 00000000 FFFFFFFF 3 00000000 00000000 A5A5FFFF
W 00001000 00AA0000 4 00000000 00000000 12AA5678
W 00002000 99000000 8 00000000 00000000 99FEF00D
R 00000000 00000000 0 00000000 A5A5FFFF A5A5FFFF
W 00000008 0000FF0F 3 00000000 00000000 A5A500F0
W 00001008 F0F0F0F0 5 00000000 00000000 125A5688
R 00000008 00000000 0 00000000 00000000 A5A500F0
R 00001008 00000000 0 00000000 00000000 125A5688
R 00000004 00000000 0 5A5A1234 5A5A1234 A5A500F0
R 00001004 00000000 0 DEADBEEF DEADBEEF 125A5688
R 00002004 00000000 0 00000001 00000001 99FEF00D
W 00003000 FFFFFFFF F 00000000 00000000 00000000
R 00003000 00000000 0 00000000 00000000 00000000
R 00003004 00000000 0 00000000 00000000 00000000
R 0000000C 00000000 0 5A5A1234 00000000 A5A500F0
W 00002008 00000001 1 00000001 00000000 99FEF00C
R 00002000 00000000 0 00000001 99FEF00C 99FEF00C

//--- src.f
rtl/periph_pkg.sv
rtl/bus_decoder.sv
rtl/gpio_bank.sv
rtl/bus_resp_mux.sv
rtl/periph_top.sv
verification/periph_assertions.sv
verification/periph_tb.sv

//--- Bender.yml
package:
  name: periph

sources:
  # Design
  - files:
      - rtl/periph_pkg.sv
      - rtl/bus_decoder.sv
      - rtl/gpio_bank.sv
      - rtl/bus_resp_mux.sv
      - rtl/periph_top.sv

  # Verification
  - target: simulation
    files:
      - verification/periph_assertions.sv
      - verification/periph_tb.sv
